/* hdl/qsim_params.svh */
`ifndef QSIM_PARAMS_SVH
`define QSIM_PARAMS_SVH

// ----------------------------------------
// memory word layout
// ----------------------------------------

// one full memory word
`define QSIM_DATA_W 32

// one amplitude part, re or im
`define QSIM_HALF_W 16

// fixed point fraction bits
`define QSIM_FRAC 8

// ----------------------------------------
// addressing and counters
// ----------------------------------------

`define QSIM_ADDR_W 10  // shared by all four memories

`define QSIM_CNT_W 16   // element and gate counters

`endif

/* hdl/qsim_pkg.sv */
`include "qsim_params.svh"

package qsim_pkg;

  // one memory word with two decodings
  // hdr only at input address 0, amp everywhere else
  typedef union packed {
    struct packed {
      logic [`QSIM_HALF_W-1:0] q_count;     // qubits
      logic [`QSIM_HALF_W-1:0] gate_count;  // gates to apply
    } hdr;
    struct packed {
      logic signed [`QSIM_HALF_W-1:0] re;
      logic signed [`QSIM_HALF_W-1:0] im;
    } amp;
  } qsim_word_u;

endpackage

/* hdl/gate_sequencer.sv */
`timescale 1ns/1ns
`include "qsim_params.svh"

module gate_sequencer import qsim_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    dut_valid,
  input  qsim_word_u              input_rd_data,
  input  logic                    pass_done,
  output logic                    dut_ready,
  output logic                    pass_clear,
  output logic                    read_scratch,
  output logic [`QSIM_ADDR_W-1:0] gate_base,
  output logic [`QSIM_CNT_W-1:0]  elem_max,
  output logic [`QSIM_CNT_W-1:0]  row_mask
);

  // ----------------------------------------
  // state encoding
  // ----------------------------------------
  localparam logic [2:0] ST_RESET   = 3'd0;
  localparam logic [2:0] ST_IDLE    = 3'd1;
  localparam logic [2:0] ST_CAPTURE = 3'd2;  // header on input read data
  localparam logic [2:0] ST_SETUP   = 3'd3;  // derived sizes settle
  localparam logic [2:0] ST_COMPUTE = 3'd4;
  localparam logic [2:0] ST_NEXT    = 3'd5;  // between two gates

  logic [2:0]             state;
  logic [2:0]             state_nx;
  qsim_word_u             hdr_r;
  logic [`QSIM_CNT_W-1:0] gate_cnt;   // gates still to run, incl. current
  logic [`QSIM_CNT_W-1:0] dim;        // 2^q
  logic [`QSIM_CNT_W-1:0] elem;       // 4^q
  logic                   last_gate;

  // ----------------------------------------
  // sizes from the qubit count
  // ----------------------------------------
  assign dim  = {{(`QSIM_CNT_W-1){1'b0}}, 1'b1} << hdr_r.hdr.q_count;
  assign elem = dim << hdr_r.hdr.q_count;

  // gate_cnt is 0 or 1
  assign last_gate = (gate_cnt[`QSIM_CNT_W-1:1] == '0);

  assign dut_ready  = (state == ST_IDLE);
  assign pass_clear = (state != ST_COMPUTE);  // counter runs only here

  // ----------------------------------------
  // state machine
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= ST_RESET;
    end else begin
      state <= state_nx;
    end
  end

  always_comb begin
    state_nx = state;
    case (state)
      ST_RESET:   state_nx = ST_IDLE;
      ST_IDLE:    if (dut_valid) state_nx = ST_CAPTURE;
      ST_CAPTURE: state_nx = ST_SETUP;
      ST_SETUP:   state_nx = ST_COMPUTE;
      ST_COMPUTE: begin
        if (pass_done) begin
          // last pass goes back through reset to idle
          state_nx = last_gate ? ST_RESET : ST_NEXT;
        end
      end
      ST_NEXT:    state_nx = ST_COMPUTE;
      default:    state_nx = ST_RESET;
    endcase
  end

  // ----------------------------------------
  // header and pass parameters
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      hdr_r <= '0;
    end else if (state == ST_CAPTURE) begin
      hdr_r <= input_rd_data;  // read of input address 0
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      gate_cnt <= '0;
      elem_max <= '0;
      row_mask <= '0;
    end else if (state == ST_SETUP) begin
      gate_cnt <= hdr_r.hdr.gate_count;
      elem_max <= elem;
      row_mask <= dim - 1'b1;
    end else if (state == ST_NEXT) begin
      gate_cnt <= gate_cnt - 1'b1;
    end
  end

  // gate matrix base and ping-pong direction
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      gate_base    <= '0;
      read_scratch <= 1'b0;
    end else if (state == ST_NEXT) begin
      gate_base    <= gate_base + elem_max[`QSIM_ADDR_W-1:0];  // next matrix
      read_scratch <= ~read_scratch;
    end else if (state != ST_COMPUTE) begin
      // gate 0 always reads the input memory
      gate_base    <= '0;
      read_scratch <= 1'b0;
    end
  end

endmodule

/* hdl/addr_gen.sv */
`timescale 1ns/1ns
`include "qsim_params.svh"

module addr_gen (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    pass_clear,
  input  logic                    read_scratch,
  input  logic [`QSIM_ADDR_W-1:0] gate_base,
  input  logic [`QSIM_CNT_W-1:0]  elem_max,
  input  logic [`QSIM_CNT_W-1:0]  row_mask,
  output logic [`QSIM_ADDR_W-1:0] gate_rd_addr,
  output logic [`QSIM_ADDR_W-1:0] vec_rd_addr,
  output logic [`QSIM_ADDR_W-1:0] vec_wr_addr,
  output logic [`QSIM_ADDR_W-1:0] input_wr_addr,
  output logic                    input_wr_en,
  output logic                    scratch_wr_en,
  output logic                    output_wr_en,
  output logic                    row_start,
  output logic                    pass_done
);

  logic [`QSIM_CNT_W-1:0]  count;
  logic [`QSIM_CNT_W-1:0]  col;      // column bits of the count
  logic                    at_max;
  logic [`QSIM_ADDR_W-1:0] row_idx;  // row of the current count
  logic [`QSIM_ADDR_W-1:0] row_d1;
  logic                    in_wr_d;
  logic                    sc_wr_d;

  assign col    = count & row_mask;
  assign at_max = (count == elem_max - 1'b1);

  // ----------------------------------------
  // element and row counters
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n || pass_clear) begin
      count   <= '0;
      row_idx <= '0;
    end else if (!at_max) begin
      count <= count + 1'b1;
      if (col == row_mask) row_idx <= row_idx + 1'b1;  // column wraps
    end
  end

  // ----------------------------------------
  // read side, one cycle after the count
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n || pass_clear) begin
      gate_rd_addr <= '0;
      vec_rd_addr  <= '0;  // input address 0 is the header
    end else begin
      gate_rd_addr <= gate_base + count[`QSIM_ADDR_W-1:0];
      // input memory holds the vector one word up
      vec_rd_addr  <= col[`QSIM_ADDR_W-1:0] + {{(`QSIM_ADDR_W-1){1'b0}}, ~read_scratch};
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      row_start <= 1'b0;
      pass_done <= 1'b0;
    end else begin
      row_start <= (col == '0);              // restart the row sum
      pass_done <= pass_clear ? 1'b0 : at_max;
    end
  end

  // ----------------------------------------
  // write side, two cycles after the count
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      row_d1        <= '0;
      vec_wr_addr   <= '0;
      input_wr_addr <= '0;
    end else begin
      row_d1        <= row_idx;
      vec_wr_addr   <= row_d1;
      input_wr_addr <= row_d1 + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n || pass_clear) begin
      in_wr_d       <= 1'b0;
      sc_wr_d       <= 1'b0;
      input_wr_en   <= 1'b0;
      scratch_wr_en <= 1'b0;
      output_wr_en  <= 1'b0;
    end else begin
      in_wr_d       <= read_scratch;   // write where we do not read
      sc_wr_d       <= ~read_scratch;
      input_wr_en   <= in_wr_d;
      scratch_wr_en <= sc_wr_d;
      output_wr_en  <= in_wr_d | sc_wr_d;
    end
  end

endmodule

/* hdl/cplx_mac.sv */
`timescale 1ns/1ns
`include "qsim_params.svh"

module cplx_mac import qsim_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       read_scratch,
  input  logic       row_start,
  input  qsim_word_u input_rd_data,
  input  qsim_word_u scratch_rd_data,
  input  qsim_word_u gate_rd_data,
  output qsim_word_u sum
);

  qsim_word_u vec;  // vector operand
  qsim_word_u acc;  // row sum so far

  // operands sign extended to full width
  logic signed [`QSIM_DATA_W-1:0] a_re;
  logic signed [`QSIM_DATA_W-1:0] a_im;
  logic signed [`QSIM_DATA_W-1:0] b_re;
  logic signed [`QSIM_DATA_W-1:0] b_im;

  logic signed [`QSIM_DATA_W-1:0] p_rr;
  logic signed [`QSIM_DATA_W-1:0] p_ii;
  logic signed [`QSIM_DATA_W-1:0] p_ri;
  logic signed [`QSIM_DATA_W-1:0] p_ir;
  logic signed [`QSIM_DATA_W-1:0] re_full;
  logic signed [`QSIM_DATA_W-1:0] im_full;

  logic [`QSIM_HALF_W-1:0] prod_re;
  logic [`QSIM_HALF_W-1:0] prod_im;
  logic [`QSIM_HALF_W-1:0] sum_re;
  logic [`QSIM_HALF_W-1:0] sum_im;

  assign vec = read_scratch ? scratch_rd_data : input_rd_data;

  assign a_re = vec.amp.re;
  assign a_im = vec.amp.im;
  assign b_re = gate_rd_data.amp.re;
  assign b_im = gate_rd_data.amp.im;

  // ----------------------------------------
  // complex product in fixed point
  // ----------------------------------------
  assign p_rr = a_re * b_re;
  assign p_ii = a_im * b_im;
  assign p_ri = a_re * b_im;
  assign p_ir = a_im * b_re;

  assign re_full = (p_rr - p_ii) >>> `QSIM_FRAC;
  assign im_full = (p_ri + p_ir) >>> `QSIM_FRAC;

  assign prod_re = re_full[`QSIM_HALF_W-1:0];  // truncate
  assign prod_im = im_full[`QSIM_HALF_W-1:0];

  // ----------------------------------------
  // row accumulation, wraps per part
  // ----------------------------------------
  assign sum_re = acc.amp.re + prod_re;
  assign sum_im = acc.amp.im + prod_im;
  assign sum    = {sum_re, sum_im};

  always_ff @(posedge clk) begin
    if (!reset_n || row_start) begin
      acc <= '0;  // first column of a row comes next
    end else begin
      acc <= sum;
    end
  end

endmodule

/* hdl/qsim_top.sv */
`timescale 1ns/1ns
`include "qsim_params.svh"

module qsim_top import qsim_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    dut_valid,
  output logic                    dut_ready,

  // input state memory
  output logic                    input_wr_en,
  output logic [`QSIM_ADDR_W-1:0] input_wr_addr,
  output qsim_word_u              input_wr_data,
  output logic [`QSIM_ADDR_W-1:0] input_rd_addr,
  input  qsim_word_u              input_rd_data,

  // output state memory, write only
  output logic                    output_wr_en,
  output logic [`QSIM_ADDR_W-1:0] output_wr_addr,
  output qsim_word_u              output_wr_data,

  // scratchpad
  output logic                    scratch_wr_en,
  output logic [`QSIM_ADDR_W-1:0] scratch_wr_addr,
  output qsim_word_u              scratch_wr_data,
  output logic [`QSIM_ADDR_W-1:0] scratch_rd_addr,
  input  qsim_word_u              scratch_rd_data,

  // gate memory, read only
  output logic [`QSIM_ADDR_W-1:0] gate_rd_addr,
  input  qsim_word_u              gate_rd_data
);

  logic                    pass_clear;
  logic                    read_scratch;
  logic                    pass_done;
  logic                    row_start;
  logic [`QSIM_ADDR_W-1:0] gate_base;
  logic [`QSIM_ADDR_W-1:0] vec_rd_addr;
  logic [`QSIM_ADDR_W-1:0] vec_wr_addr;
  logic [`QSIM_CNT_W-1:0]  elem_max;
  logic [`QSIM_CNT_W-1:0]  row_mask;
  qsim_word_u              sum;

  // ----------------------------------------
  // fan out to the memory ports
  // ----------------------------------------
  assign input_rd_addr   = vec_rd_addr;
  assign scratch_rd_addr = vec_rd_addr;
  assign output_wr_addr  = vec_wr_addr;
  assign scratch_wr_addr = vec_wr_addr;

  assign input_wr_data   = sum;  // same row sum to every target
  assign output_wr_data  = sum;
  assign scratch_wr_data = sum;

  gate_sequencer u_seq (
    .clk           (clk),
    .reset_n       (reset_n),
    .dut_valid     (dut_valid),
    .input_rd_data (input_rd_data),
    .pass_done     (pass_done),
    .dut_ready     (dut_ready),
    .pass_clear    (pass_clear),
    .read_scratch  (read_scratch),
    .gate_base     (gate_base),
    .elem_max      (elem_max),
    .row_mask      (row_mask)
  );

  addr_gen u_addr (
    .clk           (clk),
    .reset_n       (reset_n),
    .pass_clear    (pass_clear),
    .read_scratch  (read_scratch),
    .gate_base     (gate_base),
    .elem_max      (elem_max),
    .row_mask      (row_mask),
    .gate_rd_addr  (gate_rd_addr),
    .vec_rd_addr   (vec_rd_addr),
    .vec_wr_addr   (vec_wr_addr),
    .input_wr_addr (input_wr_addr),
    .input_wr_en   (input_wr_en),
    .scratch_wr_en (scratch_wr_en),
    .output_wr_en  (output_wr_en),
    .row_start     (row_start),
    .pass_done     (pass_done)
  );

  cplx_mac u_mac (
    .clk             (clk),
    .reset_n         (reset_n),
    .read_scratch    (read_scratch),
    .row_start       (row_start),
    .input_rd_data   (input_rd_data),
    .scratch_rd_data (scratch_rd_data),
    .gate_rd_data    (gate_rd_data),
    .sum             (sum)
  );

endmodule

/* test/qsim_props.sv */
`timescale 1ns/1ns

module qsim_props (
  input logic clk,
  input logic reset_n,
  input logic dut_valid,
  input logic dut_ready,
  input logic input_wr_en,
  input logic scratch_wr_en,
  input logic output_wr_en,
  input logic pass_done
);

  // ----------------------------------------
  // write enables
  // ----------------------------------------
  a_one_vector_target: assert property (@(posedge clk) disable iff (!reset_n)
    !(input_wr_en && scratch_wr_en))
    else $error("input and scratchpad written in the same cycle");

  a_quiet_when_ready: assert property (@(posedge clk) disable iff (!reset_n)
    dut_ready |-> !(input_wr_en || scratch_wr_en || output_wr_en))
    else $error("memory write while dut_ready is high");

  // ----------------------------------------
  // handshake
  // ----------------------------------------
  a_busy_after_accept: assert property (@(posedge clk) disable iff (!reset_n)
    (dut_ready && dut_valid) |=> !dut_ready)
    else $error("dut_ready still high after a start was accepted");

  // ready comes back only through reset after a finished pass
  a_ready_after_pass: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(dut_ready) |-> ($past(pass_done, 2) || !$past(reset_n, 2)))
    else $error("dut_ready rose before the final pass ended");

endmodule

/* test/qsim_tb.sv */
`timescale 1ns/1ns
`include "qsim_params.svh"

module qsim_tb import qsim_pkg::*; ();

  localparam int DEPTH = 1 << `QSIM_ADDR_W;

  logic clk;
  logic reset_n;
  logic dut_valid;
  logic dut_ready;
  logic input_wr_en, output_wr_en, scratch_wr_en;
  logic [`QSIM_ADDR_W-1:0] input_wr_addr, input_rd_addr, output_wr_addr;
  logic [`QSIM_ADDR_W-1:0] scratch_wr_addr, scratch_rd_addr, gate_rd_addr;
  qsim_word_u input_wr_data, input_rd_data, output_wr_data;
  qsim_word_u scratch_wr_data, scratch_rd_data, gate_rd_data;

  qsim_word_u input_mem [DEPTH];
  qsim_word_u output_mem [DEPTH];
  qsim_word_u scratch_mem [DEPTH];
  qsim_word_u gate_mem [DEPTH];

  // parsed tests, words laid out input, gates, expected
  string      test_name [$];
  int         test_q [$];
  int         test_m [$];
  int         test_off [$];
  qsim_word_u words [$];

  int fd;
  int cycles;
  int limit;

  qsim_top dut0 (.*);

  bind qsim_top qsim_props props0 (
    .clk(clk), .reset_n(reset_n), .dut_valid(dut_valid), .dut_ready(dut_ready),
    .input_wr_en(input_wr_en), .scratch_wr_en(scratch_wr_en),
    .output_wr_en(output_wr_en), .pass_done(pass_done)
  );

  always #2 clk = ~clk;

  // ----------------------------------------
  // memory models, one cycle read
  // ----------------------------------------
  always @(posedge clk) begin
    input_rd_data   <= input_mem[input_rd_addr];
    scratch_rd_data <= scratch_mem[scratch_rd_addr];
    gate_rd_data    <= gate_mem[gate_rd_addr];
    if (input_wr_en) input_mem[input_wr_addr] <= input_wr_data;
    if (scratch_wr_en) scratch_mem[scratch_wr_addr] <= scratch_wr_data;
    if (output_wr_en) output_mem[output_wr_addr] <= output_wr_data;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  task automatic stop_with(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped");
  endtask

  task automatic check_amp(input string name, input qsim_word_u exp, input qsim_word_u act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "amplitude mismatch");
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "control mismatch");
    end
  endtask

  // ----------------------------------------
  // pattern file
  // ----------------------------------------
  task automatic next_token(output string tok);
    string line;
    int    rc;
    tok = "";
    while (tok == "") begin
      rc = $fscanf(fd, "%s", tok);
      if (rc != 1) stop_with("pattern file ended before the end marker");
      if (tok.substr(0, 0) == "#") begin
        rc = $fgets(line, fd);  // rest of comment line
        tok = "";
      end
    end
  endtask

  task automatic load_patterns();
    string      tok;
    string      name;
    int         q, m, n;
    qsim_word_u w;
    fd = $fopen("test/qsim_patterns.txt", "r");
    if (fd == 0) stop_with("cannot open test/qsim_patterns.txt");
    next_token(tok);
    while (tok == "test") begin
      next_token(name);
      next_token(tok);
      void'($sscanf(tok, "%d", q));
      next_token(tok);
      void'($sscanf(tok, "%d", m));
      test_name.push_back(name);
      test_q.push_back(q);
      test_m.push_back(m);
      test_off.push_back(words.size());
      n = (1 << q) * (2 + m * (1 << q));  // input, gates, expected
      for (int i = 0; i < n; i++) begin
        next_token(tok);
        void'($sscanf(tok, "%h", w));
        words.push_back(w);
      end
      next_token(tok);
    end
    if (tok != "end") stop_with("unexpected token in pattern file");
    $fclose(fd);
  endtask

  function automatic qsim_word_u fill_word(input int sel, input int a);
    logic [9:0] ab;
    ab = a[9:0];
    return {sel[5:0], ab, 6'h2a, ~ab};
  endfunction

  task automatic wait_ready();
    do @(negedge clk); while (!dut_ready);
  endtask

  // ----------------------------------------
  // one run
  // ----------------------------------------
  task automatic run_test(input int t);
    int         dim, off, n_gate, gap;
    qsim_word_u hw;
    dim    = 1 << test_q[t];
    off    = test_off[t];
    n_gate = test_m[t] * dim * dim;
    for (int a = 0; a < DEPTH; a++) begin
      input_mem[a]   <= fill_word(1, a);
      output_mem[a]  <= fill_word(2, a);
      scratch_mem[a] <= fill_word(3, a);
      gate_mem[a]    <= fill_word(4, a);
    end
    hw.hdr.q_count    = test_q[t][15:0];
    hw.hdr.gate_count = test_m[t][15:0];
    input_mem[0] <= hw;
    for (int i = 0; i < dim; i++) input_mem[i+1] <= words[off+i];
    for (int i = 0; i < n_gate; i++) gate_mem[i] <= words[off+dim+i];
    gap = $urandom % 6;
    repeat (gap) @(posedge clk);
    @(posedge clk) dut_valid <= 1'b1;
    @(posedge clk) dut_valid <= 1'b0;
    @(negedge clk) check_ready({test_name[t], " busy"}, 1'b0, dut_ready);
    // stray start while busy
    @(posedge clk) dut_valid <= 1'b1;
    @(posedge clk) dut_valid <= 1'b0;
    wait_ready();
    // no start left pending from the stray pulse
    @(negedge clk) check_ready({test_name[t], " ignore"}, 1'b1, dut_ready);
    for (int i = 0; i < dim; i++) begin
      check_amp($sformatf("%s out[%0d]", test_name[t], i),
                words[off+dim+n_gate+i], output_mem[i]);
    end
  endtask

  initial begin
    void'($urandom(29659));
    clk       = 1'b0;
    reset_n   <= 1'b0;
    dut_valid <= 1'b0;
    cycles    <= 0;
    limit     = 1000000;
    load_patterns();
    limit = 0;
    foreach (test_q[t]) limit += test_m[t] * ((1 << (2 * test_q[t])) + 8) + 20;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    wait_ready();
    check_ready("reset input_wr_en", 1'b0, input_wr_en);
    check_ready("reset scratch_wr_en", 1'b0, scratch_wr_en);
    check_ready("reset output_wr_en", 1'b0, output_wr_en);
    foreach (test_q[t]) run_test(t);
    $display("Simulation passed");
    $finish;
  end

endmodule

/* test/qsim_patterns.txt */
# test <name> <q> <m>, then input vector, gate rows (row-major), expected output
# words are hex {re[15:0], im[15:0]}, 8 fraction bits
test hadamard_q1 1 1
01000000 0080ffc0
00b50000 00b50000
00b50000 ff4b0000
010fffd2 005a002d
test pingpong_m2 1 2
00400020 fff00008
00000000 01000000
01000000 00000000
01000000 00000000
00000000 00000100
fff00008 ffe00040
test pingpong_m3 1 3
00400020 fff00008
00000000 01000000
01000000 00000000
01000000 00000000
00000000 00000100
00000000 01000000
01000000 00000000
ffe00040 fff00008
test mixed_q2 2 1
01000000 00000100 00800080 ffc00020
00800000 00000080 00000000 01000000
0000ff00 01000000 ff800000 00000000
00400040 00000000 00000000 ff000000
00000000 0000ff80 00010001 00000001
ffc00020 ffc0ffc0 00800020 007f0000
test phase_q1 1 1
000affec fff90003
00000100 00000000
00000000 ff000000
0014000a 0007fffd
end

/* filelist.f */
+incdir+hdl
hdl/qsim_pkg.sv
hdl/gate_sequencer.sv
hdl/addr_gen.sv
hdl/cplx_mac.sv
hdl/qsim_top.sv
test/qsim_props.sv
test/qsim_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module qsim_tb -o qsim_sim

out=$(./obj_dir/qsim_sim 2>&1) || true
echo "$out"
echo "$out" | grep -q "Simulation passed"
